/* bench/tb_core_mem.sv */
`timescale 1ns/10ps

module tb_core_mem;
	import l15_pkg::*;
	import core_pkg::*;

	localparam int n_rows = 18;
	localparam int cycle_limit = 200 + 40 * n_rows;

	logic clk;
	logic nrst;
	logic redirect_val;
	addr_t redirect_pc;
	logic instr_val;
	word_t instr;
	addr_t instr_pc;
	logic mem_start;
	mem_op_t mem_op;
	addr_t mem_addr;
	word_t mem_wdata;
	logic mem_busy, mem_done, misaligned;
	word_t load_data;
	l15_rqtype_t transducer_l15_rqtype;
	l15_size_t transducer_l15_size;
	addr_t transducer_l15_address;
	dword_t transducer_l15_data, l15_transducer_data_0;
	logic transducer_l15_val, l15_transducer_ack, l15_transducer_header_ack;
	logic l15_transducer_val, transducer_l15_req_ack;
	l15_rettype_t l15_transducer_returntype;
	int proto_errors;
	int mem_reqs; // Load/store requests seen by the model

	// Operation table, expected load values filled from the mirror
	mem_op_t tbl_op [n_rows] = '{op_sw, op_lw, op_lb, op_lbu, op_lh, op_lhu, op_sb, op_lb,
		op_sh, op_lhu, op_lh, op_lw, op_lh, op_lw, op_sh, op_sw, op_lw, op_lb};
	addr_t tbl_addr [n_rows] = '{32'h100, 32'h100, 32'h101, 32'h103, 32'h102, 32'h100,
		32'h105, 32'h105, 32'h10a, 32'h10a, 32'h10a, 32'h10c, 32'h103, 32'h106,
		32'h111, 32'h112, 32'h110, 32'h11f};
	word_t tbl_wdata [n_rows] = '{32'h8badf00d, 0, 0, 0, 0, 0, 32'h000000a5, 0,
		32'h00007e31, 0, 0, 0, 0, 0, 32'h0000dead, 32'h12345678, 0, 0};
	logic tbl_mis [n_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 0, 0};
	word_t tbl_exp [n_rows];

	dword_t mirror [0:63]; // Expected model memory
	addr_t exp_pc = reset_pc;
	word_t exp_word;
	int n_instr = 0;
	int errors = 0;
	int cycles = 0;
	int i;

	core_mem_top i_core_mem_top (
		.clk(clk), .nrst(nrst),
		.redirect_val(redirect_val), .redirect_pc(redirect_pc),
		.instr_val(instr_val), .instr(instr), .instr_pc(instr_pc),
		.mem_start(mem_start), .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_busy(mem_busy), .mem_done(mem_done), .misaligned(misaligned),
		.load_data(load_data),
		.transducer_l15_rqtype(transducer_l15_rqtype), .transducer_l15_size(transducer_l15_size),
		.transducer_l15_address(transducer_l15_address),
		.transducer_l15_data(transducer_l15_data), .transducer_l15_val(transducer_l15_val),
		.l15_transducer_ack(l15_transducer_ack),
		.l15_transducer_header_ack(l15_transducer_header_ack),
		.l15_transducer_val(l15_transducer_val), .l15_transducer_data_0(l15_transducer_data_0),
		.l15_transducer_returntype(l15_transducer_returntype),
		.transducer_l15_req_ack(transducer_l15_req_ack)
	);

	tb_l15_model i_tb_l15_model (
		.clk(clk), .nrst(nrst),
		.rqtype(transducer_l15_rqtype), .size(transducer_l15_size),
		.address(transducer_l15_address), .data(transducer_l15_data),
		.val(transducer_l15_val), .ack(l15_transducer_ack),
		.header_ack(l15_transducer_header_ack), .resp_val(l15_transducer_val),
		.resp_data_0(l15_transducer_data_0), .resp_returntype(l15_transducer_returntype),
		.req_ack(transducer_l15_req_ack), .proto_errors(proto_errors), .mem_reqs(mem_reqs)
	);

	initial
		clk = 1'b0;
	always #10 clk = ~clk;

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	function automatic logic is_store_op(input mem_op_t op);
		return (op == op_sb) || (op == op_sh) || (op == op_sw);
	endfunction

	// Load value from the mirror, little endian with RV32 extension
	function automatic word_t expect_load(input mem_op_t op, input addr_t a);
		dword_t d;
		word_t w;
		word_t res;
		int k;
		d = mirror[a[8:3]];
		for (k = 0; k < 4; k++)
			w[8*k +: 8] = d[8*((a[2:0] + k) % 8) +: 8];
		case (op)
			op_lb: res = {{24{w[7]}}, w[7:0]};
			op_lbu: res = {24'h0, w[7:0]};
			op_lh: res = {{16{w[15]}}, w[15:0]};
			op_lhu: res = {16'h0, w[15:0]};
			default: res = w;
		endcase
		return res;
	endfunction

	task automatic store_to_mirror(input mem_op_t op, input addr_t a, input word_t wd);
		int nbytes;
		int k;
		nbytes = (op == op_sb) ? 1 : (op == op_sh) ? 2 : 4;
		for (k = 0; k < nbytes; k++)
			mirror[a[8:3]][8*(a[2:0] + k) +: 8] = wd[8*k +: 8];
	endtask

	task automatic wait_instrs(input int n);
		int target;
		target = n_instr + n;
		while (n_instr < target)
			@(posedge clk);
	endtask

	// Ends on the edge closing a fetch transfer
	task automatic wait_fetch_xfer;
		do
			@(posedge clk);
		while (!(transducer_l15_val && l15_transducer_ack && transducer_l15_rqtype == rq_imiss));
	endtask

	task automatic run_row(input int r);
		int reqs_before;
		int reqs_exp;
		string name;
		name = $sformatf("row %0d", r);
		reqs_before = mem_reqs;
		reqs_exp = reqs_before + (tbl_mis[r] ? 0 : 1); // Misaligned never reaches the cache
		#2;
		mem_start = 1'b1;
		mem_op = tbl_op[r];
		mem_addr = tbl_addr[r];
		mem_wdata = tbl_wdata[r];
		@(posedge clk);
		#2 mem_start = 1'b0;
		mem_op = op_none;
		@(posedge clk);
		while (!mem_done)
			@(posedge clk);
		check_bit({name, " misaligned"}, tbl_mis[r], misaligned);
		if (!tbl_mis[r] && !is_store_op(tbl_op[r]))
			check_word({name, " load_data"}, tbl_exp[r], load_data);
		if (mem_reqs != reqs_exp)
		begin
			errors++;
			$display("%s made %0d cache requests, %0d expected", name,
				mem_reqs - reqs_before, reqs_exp - reqs_before);
		end
	endtask

	task automatic report_counts;
		$display("Errors: %0d in checks, %0d in protocol", errors, proto_errors);
	endtask

	// Fetch checker, next PC follows redirects
	always @(posedge clk)
	begin
		if (nrst)
		begin
			if (redirect_val)
				exp_pc = redirect_pc;
			else if (instr_val)
			begin
				exp_word = exp_pc[2] ? i_tb_l15_model.mem[exp_pc[8:3]][63:32] :
					i_tb_l15_model.mem[exp_pc[8:3]][31:0];
				check_addr("fetch instr_pc", exp_pc, instr_pc);
				check_word("fetch instr", exp_word, instr);
				exp_pc = exp_pc + 32'd4;
				n_instr++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			report_counts();
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin
		nrst = 1'b0;
		redirect_val = 1'b0;
		redirect_pc = '0;
		mem_start = 1'b0;
		mem_op = op_none;
		mem_addr = '0;
		mem_wdata = '0;
		void'($urandom(32'hb127af34));
		for (i = 0; i < 64; i++)
		begin
			mirror[i] = {$urandom, $urandom};
			i_tb_l15_model.mem[i] = mirror[i];
		end
		// Walk the table once for expected loads
		for (i = 0; i < n_rows; i++)
		begin
			tbl_exp[i] = '0;
			if (!tbl_mis[i] && is_store_op(tbl_op[i]))
				store_to_mirror(tbl_op[i], tbl_addr[i], tbl_wdata[i]);
			else if (!tbl_mis[i])
				tbl_exp[i] = expect_load(tbl_op[i], tbl_addr[i]);
		end
		repeat (16) @(posedge clk);
		check_bit("reset cache val", 1'b0, transducer_l15_val);
		check_bit("reset req_ack", 1'b0, transducer_l15_req_ack);
		check_bit("reset instr_val", 1'b0, instr_val);
		check_bit("reset mem_done", 1'b0, mem_done);
		check_bit("reset mem_busy", 1'b0, mem_busy);
		#2 nrst = 1'b1;
		wait_instrs(6);
		wait_fetch_xfer(); // Redirect with response in flight
		#2 redirect_val = 1'b1;
		redirect_pc = 32'h0000_0080;
		@(posedge clk);
		#2 redirect_val = 1'b0;
		wait_instrs(4);
		do
			@(posedge clk);
		while (!instr_val);
		#2 redirect_val = 1'b1; // Request raised, not yet acked
		redirect_pc = 32'h0000_0040;
		@(posedge clk);
		#2 redirect_val = 1'b0;
		wait_instrs(4);
		for (i = 0; i < n_rows; i++)
		begin
			if (i % 2 == 0)
				wait_fetch_xfer(); // Start while fetch is outstanding
			run_row(i);
		end
		wait_instrs(3); // Fetch resumes after the last op
		for (i = 0; i < 64; i++)
			if (i_tb_l15_model.mem[i] !== mirror[i])
			begin
				errors++;
				$display("Model memory at doubleword %0d differs from the expected contents", i);
			end
		report_counts();
		if (errors == 0 && proto_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* bench/tb_l15_model.sv */
`timescale 1ns/10ps

module tb_l15_model (
	input logic clk,
	input logic nrst,
	input l15_pkg::l15_rqtype_t rqtype,
	input l15_pkg::l15_size_t size,
	input core_pkg::addr_t address,
	input l15_pkg::dword_t data,
	input logic val,
	output logic ack,
	output logic header_ack,
	output logic resp_val,
	output l15_pkg::dword_t resp_data_0,
	output l15_pkg::l15_rettype_t resp_returntype,
	input logic req_ack,
	output int proto_errors,
	output int mem_reqs
);
	import l15_pkg::*;
	import core_pkg::*;

	dword_t mem [0:63]; // 512 bytes, indexed by address bits 8..3
	logic pend; // Request raised last cycle, not yet acked
	logic owed; // Response still to be returned
	logic [1:0] delay;
	logic [5:0] idx_q;
	l15_rqtype_t rq_q;
	logic [103:0] req_q; // Request fields of the previous cycle
	dword_t wr;
	int lane;
	int k;

	// Ack one cycle after val first seen
	assign ack = val && pend && !owed;
	assign header_ack = ack;

	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pend <= 1'b0;
			owed <= 1'b0;
			delay <= 2'd0;
			resp_val <= 1'b0;
			resp_data_0 <= '0;
			resp_returntype <= '0;
			proto_errors <= 0;
			mem_reqs <= 0;
		end
		else
		begin
			pend <= val && !ack;
			req_q <= {rqtype, size, address, data};
			resp_val <= 1'b0;
			// Protocol monitor
			if (val && owed)
			begin
				proto_errors <= proto_errors + 1;
				$display("Protocol error: request raised while a response is still owed");
			end
			if (pend && val && ({rqtype, size, address, data} != req_q))
			begin
				proto_errors <= proto_errors + 1;
				$display("Protocol error: request fields changed before the ack");
			end
			if (resp_val && !req_ack)
			begin
				proto_errors <= proto_errors + 1;
				$display("Protocol error: response was not acknowledged");
			end
			if (ack)
			begin
				owed <= 1'b1;
				delay <= 2'd2; // Response three cycles after the transfer
				idx_q <= address[8:3];
				rq_q <= rqtype;
				if (rqtype != rq_imiss)
					mem_reqs <= mem_reqs + 1;
				if (rqtype == rq_store)
				begin
					wr = mem[address[8:3]];
					for (k = 0; k < (1 << size); k++)
					begin
						lane = (address[2:0] + k) % 8;
						wr[8*lane +: 8] = data[8*lane +: 8]; // Lane taken from replicated data
					end
					mem[address[8:3]] <= wr;
				end
			end
			else if (owed && (delay != 2'd0))
			begin
				delay <= delay - 2'd1;
				if (delay == 2'd1)
				begin
					resp_val <= 1'b1;
					resp_data_0 <= mem[idx_q];
					if (rq_q == rq_imiss)
						resp_returntype <= rt_ifill;
					else
						resp_returntype <= (rq_q == rq_store) ? rt_st_ack : rt_load;
				end
			end
			if (resp_val)
				owed <= 1'b0; // Port free again
		end
	end

endmodule

/* design/core_mem_top.sv */
`timescale 1ns/10ps

module core_mem_top (
	input logic clk,
	input logic nrst,
	input logic redirect_val,
	input core_pkg::addr_t redirect_pc,
	output logic instr_val,
	output core_pkg::word_t instr,
	output core_pkg::addr_t instr_pc,
	input logic mem_start,
	input core_pkg::mem_op_t mem_op,
	input core_pkg::addr_t mem_addr,
	input core_pkg::word_t mem_wdata,
	output logic mem_busy,
	output logic mem_done,
	output logic misaligned,
	output core_pkg::word_t load_data,
	output l15_pkg::l15_rqtype_t transducer_l15_rqtype,
	output l15_pkg::l15_size_t transducer_l15_size,
	output core_pkg::addr_t transducer_l15_address,
	output l15_pkg::dword_t transducer_l15_data,
	output logic transducer_l15_val,
	input logic l15_transducer_ack,
	input logic l15_transducer_header_ack,
	input logic l15_transducer_val,
	input l15_pkg::dword_t l15_transducer_data_0,
	input l15_pkg::l15_rettype_t l15_transducer_returntype,
	output logic transducer_l15_req_ack
);
	import l15_pkg::*;
	import core_pkg::*;

	logic fetch_outstanding, mem_pending; // Arbiter switch conditions

	// Fetch side of the arbiter
	l15_rqtype_t instr_l15_rqtype;
	l15_size_t instr_l15_size;
	addr_t instr_l15_address;
	dword_t instr_l15_data, l15_instr_data_0;
	l15_rettype_t l15_instr_returntype;
	logic instr_l15_val, l15_instr_ack, l15_instr_header_ack, l15_instr_val, instr_l15_req_ack;

	// Load/store side of the arbiter
	l15_rqtype_t mem_l15_rqtype;
	l15_size_t mem_l15_size;
	addr_t mem_l15_address;
	dword_t mem_l15_data, l15_mem_data_0;
	l15_rettype_t l15_mem_returntype;
	logic mem_l15_val, l15_mem_ack, l15_mem_header_ack, l15_mem_val, mem_l15_req_ack;

	fetch_unit i_fetch_unit (
		.clk(clk), .nrst(nrst),
		.redirect_val(redirect_val), .redirect_pc(redirect_pc),
		.instr_val(instr_val), .instr(instr), .instr_pc(instr_pc),
		.fetch_outstanding(fetch_outstanding),
		.rqtype(instr_l15_rqtype), .size(instr_l15_size), .address(instr_l15_address),
		.data(instr_l15_data), .val(instr_l15_val),
		.ack(l15_instr_ack), .header_ack(l15_instr_header_ack),
		.resp_val(l15_instr_val), .resp_data_0(l15_instr_data_0),
		.resp_returntype(l15_instr_returntype), .req_ack(instr_l15_req_ack)
	);

	lsu i_lsu (
		.clk(clk), .nrst(nrst),
		.mem_start(mem_start), .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_busy(mem_busy), .mem_pending(mem_pending), .mem_done(mem_done),
		.misaligned(misaligned), .load_data(load_data),
		.rqtype(mem_l15_rqtype), .size(mem_l15_size), .address(mem_l15_address),
		.data(mem_l15_data), .val(mem_l15_val),
		.ack(l15_mem_ack), .header_ack(l15_mem_header_ack),
		.resp_val(l15_mem_val), .resp_data_0(l15_mem_data_0),
		.resp_returntype(l15_mem_returntype), .req_ack(mem_l15_req_ack)
	);

	// Single cache port shared by both requesters
	l15_arbiter i_l15_arbiter (
		.clk(clk), .nrst(nrst),
		.fetch_outstanding(fetch_outstanding), .mem_pending(mem_pending),
		.instr_l15_rqtype(instr_l15_rqtype), .instr_l15_size(instr_l15_size),
		.instr_l15_address(instr_l15_address), .instr_l15_data(instr_l15_data),
		.instr_l15_val(instr_l15_val), .l15_instr_ack(l15_instr_ack),
		.l15_instr_header_ack(l15_instr_header_ack), .l15_instr_val(l15_instr_val),
		.l15_instr_data_0(l15_instr_data_0), .l15_instr_returntype(l15_instr_returntype),
		.instr_l15_req_ack(instr_l15_req_ack),
		.mem_l15_rqtype(mem_l15_rqtype), .mem_l15_size(mem_l15_size),
		.mem_l15_address(mem_l15_address), .mem_l15_data(mem_l15_data),
		.mem_l15_val(mem_l15_val), .l15_mem_ack(l15_mem_ack),
		.l15_mem_header_ack(l15_mem_header_ack), .l15_mem_val(l15_mem_val),
		.l15_mem_data_0(l15_mem_data_0), .l15_mem_returntype(l15_mem_returntype),
		.mem_l15_req_ack(mem_l15_req_ack),
		.transducer_l15_rqtype(transducer_l15_rqtype),
		.transducer_l15_size(transducer_l15_size),
		.transducer_l15_address(transducer_l15_address),
		.transducer_l15_data(transducer_l15_data),
		.transducer_l15_val(transducer_l15_val),
		.l15_transducer_ack(l15_transducer_ack),
		.l15_transducer_header_ack(l15_transducer_header_ack),
		.l15_transducer_val(l15_transducer_val),
		.l15_transducer_data_0(l15_transducer_data_0),
		.l15_transducer_returntype(l15_transducer_returntype),
		.transducer_l15_req_ack(transducer_l15_req_ack)
	);

endmodule

/* design/core_pkg.sv */
package core_pkg;

	typedef logic [31:0] word_t; // Data word
	typedef logic [31:0] addr_t; // Byte address
	typedef logic [3:0] mem_op_t; // Load/store operation code

	// Memory operations from the execute side
	localparam mem_op_t op_none = 4'd0;
	localparam mem_op_t op_lb = 4'd1;
	localparam mem_op_t op_lbu = 4'd2;
	localparam mem_op_t op_lh = 4'd3;
	localparam mem_op_t op_lhu = 4'd4;
	localparam mem_op_t op_lw = 4'd5;
	localparam mem_op_t op_sb = 4'd6;
	localparam mem_op_t op_sh = 4'd7;
	localparam mem_op_t op_sw = 4'd8;

	// Cache port owner
	typedef enum logic [1:0] {
		arb_instr, // Fetch connected
		arb_wait, // Memory op waiting, fetch draining
		arb_mem // Load/store connected
	} arb_state_t;

	typedef enum logic [1:0] {f_idle, f_req, f_resp} fetch_state_t;

	typedef enum logic [1:0] {m_idle, m_req, m_resp} lsu_state_t;

	localparam addr_t reset_pc = 32'h0000_0000; // First fetch address

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
	input logic clk,
	input logic nrst,
	input logic redirect_val,
	input core_pkg::addr_t redirect_pc,
	output logic instr_val,
	output core_pkg::word_t instr,
	output core_pkg::addr_t instr_pc,
	output logic fetch_outstanding,
	output l15_pkg::l15_rqtype_t rqtype,
	output l15_pkg::l15_size_t size,
	output core_pkg::addr_t address,
	output l15_pkg::dword_t data,
	output logic val,
	input logic ack,
	input logic header_ack,
	input logic resp_val,
	input l15_pkg::dword_t resp_data_0,
	input l15_pkg::l15_rettype_t resp_returntype,
	output logic req_ack
);
	import l15_pkg::*;
	import core_pkg::*;

	fetch_state_t state;
	addr_t fetch_pc; // Address of the request on the port
	addr_t next_pc; // Address for the following request
	addr_t pc_sel;
	logic stale; // Response in flight belongs to the old path
	logic sent;
	logic resp_hit;

	// Header ack comes with ack
	assign sent = val && (ack || header_ack);
	assign resp_hit = (state == f_resp) && resp_val && (resp_returntype == rt_ifill);

	assign rqtype = rq_imiss;
	assign size = sz_4b;
	assign address = fetch_pc;
	assign data = '0; // Fetch carries no payload
	assign val = (state == f_req);
	assign req_ack = (state == f_resp) && resp_val;
	assign fetch_outstanding = (state == f_resp);

	// Upper word of the doubleword when PC bit 2 set
	assign instr = fetch_pc[2] ? resp_data_0[63:32] : resp_data_0[31:0];
	assign instr_pc = fetch_pc;
	assign instr_val = resp_hit && !stale && !redirect_val; // Old path suppressed

	// Redirect wins over sequential step
	assign pc_sel = redirect_val ? redirect_pc :
		(resp_hit && !stale) ? fetch_pc + 32'd4 : next_pc;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= f_idle;
			stale <= 1'b0;
			fetch_pc <= reset_pc;
			next_pc <= reset_pc;
		end
		else
		begin
			next_pc <= pc_sel;
			case (state)
				f_idle:
				begin
					state <= f_req;
					fetch_pc <= pc_sel;
					stale <= 1'b0;
				end
				f_req:
				begin
					if (redirect_val)
						stale <= 1'b1; // Request stays stable, answer dropped later
					if (sent)
						state <= f_resp;
				end
				default:
				begin
					if (redirect_val)
						stale <= 1'b1;
					// Straight back to request, no idle cycle
					if (resp_hit)
					begin
						state <= f_req;
						fetch_pc <= pc_sel;
						stale <= 1'b0;
					end
				end
			endcase
		end
	end

endmodule

/* design/l15_arbiter.sv */
`timescale 1ns/10ps

module l15_arbiter (
	input logic clk,
	input logic nrst,
	input logic fetch_outstanding,
	input logic mem_pending,
	// Fetch side
	input l15_pkg::l15_rqtype_t instr_l15_rqtype,
	input l15_pkg::l15_size_t instr_l15_size,
	input core_pkg::addr_t instr_l15_address,
	input l15_pkg::dword_t instr_l15_data,
	input logic instr_l15_val,
	output logic l15_instr_ack,
	output logic l15_instr_header_ack,
	output logic l15_instr_val,
	output l15_pkg::dword_t l15_instr_data_0,
	output l15_pkg::l15_rettype_t l15_instr_returntype,
	input logic instr_l15_req_ack,
	// Load/store side
	input l15_pkg::l15_rqtype_t mem_l15_rqtype,
	input l15_pkg::l15_size_t mem_l15_size,
	input core_pkg::addr_t mem_l15_address,
	input l15_pkg::dword_t mem_l15_data,
	input logic mem_l15_val,
	output logic l15_mem_ack,
	output logic l15_mem_header_ack,
	output logic l15_mem_val,
	output l15_pkg::dword_t l15_mem_data_0,
	output l15_pkg::l15_rettype_t l15_mem_returntype,
	input logic mem_l15_req_ack,
	// Cache port
	output l15_pkg::l15_rqtype_t transducer_l15_rqtype,
	output l15_pkg::l15_size_t transducer_l15_size,
	output core_pkg::addr_t transducer_l15_address,
	output l15_pkg::dword_t transducer_l15_data,
	output logic transducer_l15_val,
	input logic l15_transducer_ack,
	input logic l15_transducer_header_ack,
	input logic l15_transducer_val,
	input l15_pkg::dword_t l15_transducer_data_0,
	input l15_pkg::l15_rettype_t l15_transducer_returntype,
	output logic transducer_l15_req_ack
);
	import core_pkg::*;

	arb_state_t state;
	logic instr_own; // Fetch may issue
	logic mem_own; // Load/store owns both directions

	assign instr_own = (state == arb_instr);
	assign mem_own = (state == arb_mem);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state <= arb_instr;
		else
		begin
			case (state)
				arb_instr:
					if (mem_pending)
						state <= arb_wait;
				arb_wait:
					// Fetch in flight must drain first
					if (!fetch_outstanding || l15_transducer_val)
						state <= arb_mem;
				default:
					if (!mem_pending)
						state <= arb_instr; // No further memory op
			endcase
		end
	end

	// Request fields follow the owner, val blocked in wait
	assign transducer_l15_rqtype = mem_own ? mem_l15_rqtype : instr_l15_rqtype;
	assign transducer_l15_size = mem_own ? mem_l15_size : instr_l15_size;
	assign transducer_l15_address = mem_own ? mem_l15_address : instr_l15_address;
	assign transducer_l15_data = mem_own ? mem_l15_data : instr_l15_data;
	assign transducer_l15_val = instr_own ? instr_l15_val : (mem_own && mem_l15_val);

	// Acks only to the side allowed to issue
	assign l15_instr_ack = instr_own && l15_transducer_ack;
	assign l15_instr_header_ack = instr_own && l15_transducer_header_ack;
	assign l15_mem_ack = mem_own && l15_transducer_ack;
	assign l15_mem_header_ack = mem_own && l15_transducer_header_ack;

	// Responses go to fetch in instr and wait states
	assign l15_instr_val = !mem_own && l15_transducer_val;
	assign l15_instr_data_0 = mem_own ? '0 : l15_transducer_data_0;
	assign l15_instr_returntype = mem_own ? '0 : l15_transducer_returntype;
	assign l15_mem_val = mem_own && l15_transducer_val;
	assign l15_mem_data_0 = mem_own ? l15_transducer_data_0 : '0;
	assign l15_mem_returntype = mem_own ? l15_transducer_returntype : '0;
	assign transducer_l15_req_ack = mem_own ? mem_l15_req_ack : instr_l15_req_ack;

endmodule

/* design/l15_pkg.sv */
package l15_pkg;

	// One cache data beat, byte k of the doubleword in bits 8k+7..8k
	typedef logic [63:0] dword_t;
	typedef logic [4:0] l15_rqtype_t; // Request type field
	typedef logic [2:0] l15_size_t; // Log2 of access size in bytes
	typedef logic [3:0] l15_rettype_t; // Response type field

	// Request types
	localparam l15_rqtype_t rq_load = 5'b00000;
	localparam l15_rqtype_t rq_store = 5'b00001;
	localparam l15_rqtype_t rq_imiss = 5'b10000; // Instruction fetch

	// Access sizes
	localparam l15_size_t sz_1b = 3'b000;
	localparam l15_size_t sz_2b = 3'b001;
	localparam l15_size_t sz_4b = 3'b010;

	// Return types
	localparam l15_rettype_t rt_load = 4'b0000;
	localparam l15_rettype_t rt_ifill = 4'b0001;
	localparam l15_rettype_t rt_st_ack = 4'b0100; // Store completion

endpackage

/* design/lsu.sv */
`timescale 1ns/10ps

module lsu (
	input logic clk,
	input logic nrst,
	input logic mem_start,
	input core_pkg::mem_op_t mem_op,
	input core_pkg::addr_t mem_addr,
	input core_pkg::word_t mem_wdata,
	output logic mem_busy,
	output logic mem_pending,
	output logic mem_done,
	output logic misaligned,
	output core_pkg::word_t load_data,
	output l15_pkg::l15_rqtype_t rqtype,
	output l15_pkg::l15_size_t size,
	output core_pkg::addr_t address,
	output l15_pkg::dword_t data,
	output logic val,
	input logic ack,
	input logic header_ack,
	input logic resp_val,
	input l15_pkg::dword_t resp_data_0,
	input l15_pkg::l15_rettype_t resp_returntype,
	output logic req_ack
);
	import l15_pkg::*;
	import core_pkg::*;

	lsu_state_t state;
	logic mis_q; // Current op failed alignment
	mem_op_t op_q;
	addr_t addr_q;
	word_t wdata_q;
	word_t load_q; // Last load result
	word_t load_ext;
	dword_t shifted;
	logic start_ok;
	logic bad_align;
	logic is_store;
	logic resp_hit;

	assign start_ok = mem_start && !mem_busy && (mem_op != op_none);
	assign is_store = (op_q == op_sb) || (op_q == op_sh) || (op_q == op_sw);

	// Natural alignment check on the incoming address
	always_comb
	begin
		case (mem_op)
			op_lh, op_lhu, op_sh: bad_align = mem_addr[0];
			op_lw, op_sw: bad_align = |mem_addr[1:0];
			default: bad_align = 1'b0;
		endcase
	end

	// Size code and store data copied into every lane
	always_comb
	begin
		case (op_q)
			op_lb, op_lbu, op_sb:
			begin
				size = sz_1b;
				data = {8{wdata_q[7:0]}};
			end
			op_lh, op_lhu, op_sh:
			begin
				size = sz_2b;
				data = {4{wdata_q[15:0]}};
			end
			default:
			begin
				size = sz_4b;
				data = {2{wdata_q}};
			end
		endcase
	end

	assign rqtype = is_store ? rq_store : rq_load;
	assign address = addr_q;
	assign val = (state == m_req);

	// Addressed bytes moved down to bit 0
	assign shifted = resp_data_0 >> {addr_q[2:0], 3'b000};
	always_comb
	begin
		case (op_q)
			op_lb: load_ext = {{24{shifted[7]}}, shifted[7:0]};
			op_lbu: load_ext = {24'h0, shifted[7:0]};
			op_lh: load_ext = {{16{shifted[15]}}, shifted[15:0]};
			op_lhu: load_ext = {16'h0, shifted[15:0]};
			default: load_ext = shifted[31:0];
		endcase
	end

	// Store finishes on its store ack, load on load data
	assign resp_hit = (state == m_resp) && !mis_q && resp_val &&
		(resp_returntype == (is_store ? rt_st_ack : rt_load));
	assign req_ack = (state == m_resp) && !mis_q && resp_val;

	assign mem_done = (state == m_resp) && (mis_q || resp_hit);
	assign misaligned = (state == m_resp) && mis_q;
	assign mem_busy = (state != m_idle);
	assign mem_pending = mem_busy && !mem_done; // Arbiter request
	assign load_data = (resp_hit && !is_store) ? load_ext : load_q;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= m_idle;
			mis_q <= 1'b0;
		end
		else
		begin
			case (state)
				m_idle:
					if (start_ok)
					begin
						mis_q <= bad_align;
						state <= bad_align ? m_resp : m_req; // Misaligned skips the cache
					end
				m_req:
					if (ack || header_ack)
						state <= m_resp;
				default:
					if (mem_done)
						state <= m_idle;
			endcase
		end
	end

	// Operation payload
	always_ff @(posedge clk)
	begin
		if (start_ok)
		begin
			op_q <= mem_op;
			addr_q <= mem_addr;
			wdata_q <= mem_wdata;
		end
		if (resp_hit && !is_store)
			load_q <= load_ext;
	end

endmodule

/* files.f */
design/l15_pkg.sv
design/core_pkg.sv
design/fetch_unit.sv
design/lsu.sv
design/l15_arbiter.sv
design/core_mem_top.sv
bench/tb_l15_model.sv
bench/tb_core_mem.sv
